// ==== source/pe_stream_pkg.sv ====
package pe_stream_pkg;

    // operation applied by a processing element to each lane
    typedef enum logic [1:0] {
        OP_INC  = 2'd0,
        OP_XOR  = 2'd1,
        OP_ROTL = 2'd2,
        OP_SWAP = 2'd3
    } pe_op_e;

    // port 0 is the dispatcher and ports 1..4 are the PEs
    localparam int NUM_PORTS = 5;

    // width of a switch port index
    localparam int PORTW = 3;

    // lane width inside the data word
    localparam int LANEW = 32;

    // key used by the xor element
    localparam logic [LANEW-1:0] XOR_KEY = 32'ha5a5a5a5;

endpackage

// ==== source/rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [pe_stream_pkg::NUM_PORTS-1:0] request,
    input  logic                                advance,
    output logic [pe_stream_pkg::NUM_PORTS-1:0] grant
);

    localparam int N  = pe_stream_pkg::NUM_PORTS;
    localparam int PW = pe_stream_pkg::PORTW;

    // first input to look at on the next grant
    logic [PW-1:0] ptr;
    logic [PW-1:0] gnt_idx;

    // search from the pointer, wrapping around
    always_comb begin : pick
        logic found;
        int   idx;
        found   = 1'b0;
        grant   = '0;
        gnt_idx = '0;
        for (int off = 0; off < N; off++) begin
            idx = (int'(ptr) + off) % N;
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                gnt_idx    = PW'(idx);
                found      = 1'b1;
            end
        end
    end

    // pointer moves just past the winner once its beat is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (advance && (|grant)) begin
            if (gnt_idx == PW'(N - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= gnt_idx + PW'(1);
            end
        end
    end

endmodule

// ==== source/stream_switch.sv ====
`timescale 1ns/10ps

module stream_switch #(
    parameter int DATAW = 128
) (
    input  logic                                                 clk,
    input  logic                                                 rst,

    // one input lane per port
    input  logic [pe_stream_pkg::NUM_PORTS-1:0]                  s_tvalid,
    output logic [pe_stream_pkg::NUM_PORTS-1:0]                  s_tready,
    input  logic [pe_stream_pkg::NUM_PORTS*DATAW-1:0]            s_tdata,
    input  logic [pe_stream_pkg::NUM_PORTS*pe_stream_pkg::PORTW-1:0] s_tdest,

    // each output is a single beat register
    output logic [pe_stream_pkg::NUM_PORTS-1:0]                  m_tvalid,
    input  logic [pe_stream_pkg::NUM_PORTS-1:0]                  m_tready,
    output logic [pe_stream_pkg::NUM_PORTS*DATAW-1:0]            m_tdata,
    output logic [pe_stream_pkg::NUM_PORTS*pe_stream_pkg::PORTW-1:0] m_tsrc
);

    localparam int N  = pe_stream_pkg::NUM_PORTS;
    localparam int PW = pe_stream_pkg::PORTW;

    // req_mat[o][i] is high when input i wants output o
    logic [N-1:0] req_mat [N];
    logic [N-1:0] gnt_mat [N];
    logic [N-1:0] take;
    logic [N-1:0] load;

    // out of range destinations match no output
    always_comb begin
        for (int o = 0; o < N; o++) begin
            for (int i = 0; i < N; i++) begin
                req_mat[o][i] = s_tvalid[i] && (s_tdest[i*PW +: PW] == PW'(o));
            end
        end
    end

    // an input is ready only when its grant lands in a free register
    always_comb begin
        s_tready = '0;
        for (int o = 0; o < N; o++) begin
            for (int i = 0; i < N; i++) begin
                if (gnt_mat[o][i] && take[o]) begin
                    s_tready[i] = 1'b1;
                end
            end
        end
    end

    for (genvar o = 0; o < N; o++) begin : g_out
        logic             out_valid;
        logic [DATAW-1:0] out_data;
        logic [PW-1:0]    out_src;
        logic [DATAW-1:0] sel_data;
        logic [PW-1:0]    sel_src;

        rr_arbiter i_arb (
            .clk     (clk),
            .rst     (rst),
            .request (req_mat[o]),
            .advance (load[o]),
            .grant   (gnt_mat[o])
        );

        // register is free when empty or draining this cycle
        assign take[o] = !out_valid || m_tready[o];
        assign load[o] = (|gnt_mat[o]) && take[o];

        // select the granted beat
        always_comb begin
            sel_data = '0;
            sel_src  = '0;
            for (int i = 0; i < N; i++) begin
                if (gnt_mat[o][i]) begin
                    sel_data = s_tdata[i*DATAW +: DATAW];
                    sel_src  = PW'(i);
                end
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                out_valid <= 1'b0;
            end else if (load[o]) begin
                out_valid <= 1'b1;
            end else if (m_tready[o]) begin
                out_valid <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (load[o]) begin
                out_data <= sel_data;
                out_src  <= sel_src;
            end
        end

        assign m_tvalid[o]             = out_valid;
        assign m_tdata[o*DATAW +: DATAW] = out_data;
        assign m_tsrc[o*PW +: PW]        = out_src;
    end

endmodule

// ==== source/axis_pe.sv ====
`timescale 1ns/10ps

module axis_pe #(
    parameter int                    DATAW = 128,
    parameter pe_stream_pkg::pe_op_e OP    = pe_stream_pkg::OP_INC
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             in_tvalid,
    output logic             in_tready,
    input  logic [DATAW-1:0] in_tdata,

    output logic             out_tvalid,
    input  logic             out_tready,
    output logic [DATAW-1:0] out_tdata
);

    localparam int LW     = pe_stream_pkg::LANEW;
    localparam int NLANES = DATAW / LW;

    logic             s1_valid;
    logic [DATAW-1:0] s1_data;
    logic             s2_valid;
    logic [DATAW-1:0] s2_data;
    logic             s2_load_ok;

    // lane-wise transform for this element's operation
    function automatic logic [DATAW-1:0] apply_op(input logic [DATAW-1:0] d);
        logic [DATAW-1:0] r;
        logic [LW-1:0]    lane;
        r = '0;
        for (int l = 0; l < NLANES; l++) begin
            lane = d[l*LW +: LW];
            case (OP)
                pe_stream_pkg::OP_INC:  r[l*LW +: LW] = lane + LW'(1);
                pe_stream_pkg::OP_XOR:  r[l*LW +: LW] = lane ^ pe_stream_pkg::XOR_KEY;
                pe_stream_pkg::OP_ROTL: r[l*LW +: LW] = (lane << 8) | (lane >> (LW - 8));
                // lane order reversed
                default:                r[(NLANES-1-l)*LW +: LW] = lane;
            endcase
        end
        return r;
    endfunction

    // each stage moves when empty or when the next one moves
    assign s2_load_ok = !s2_valid || out_tready;
    assign in_tready  = !s1_valid || s2_load_ok;

    // stage one holds the raw beat
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (in_tready) begin
            s1_valid <= in_tvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_tready && in_tvalid) begin
            s1_data <= in_tdata;
        end
    end

    // stage two holds the result
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (s2_load_ok) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_load_ok && s1_valid) begin
            s2_data <= apply_op(s1_data);
        end
    end

    assign out_tvalid = s2_valid;
    assign out_tdata  = s2_data;

endmodule

// ==== source/task_dispatcher.sv ====
`timescale 1ns/10ps

module task_dispatcher #(
    parameter int DATAW     = 128,
    parameter int IDW       = 2,
    parameter int USERW     = 4,
    parameter int DESTW     = 4,
    parameter int TAG_DEPTH = 4
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            axis_s_tvalid,
    output logic                            axis_s_tready,
    input  logic [DATAW-1:0]                axis_s_tdata,
    input  logic                            axis_s_tlast,
    input  logic [IDW-1:0]                  axis_s_tid,
    input  logic [USERW-1:0]                axis_s_tuser,
    input  logic [DESTW-1:0]                axis_s_tdest,

    output logic                            axis_m_tvalid,
    input  logic                            axis_m_tready,
    output logic [DATAW-1:0]                axis_m_tdata,
    output logic                            axis_m_tlast,
    output logic [IDW-1:0]                  axis_m_tid,
    output logic [USERW-1:0]                axis_m_tuser,
    output logic [DESTW-1:0]                axis_m_tdest,

    output logic                            req_tvalid,
    input  logic                            req_tready,
    output logic [DATAW-1:0]                req_tdata,
    output logic [pe_stream_pkg::PORTW-1:0] req_tdest,

    input  logic                            rsp_tvalid,
    output logic                            rsp_tready,
    input  logic [DATAW-1:0]                rsp_tdata,
    input  logic [pe_stream_pkg::PORTW-1:0] rsp_tsrc
);

    localparam int PW     = pe_stream_pkg::PORTW;
    localparam int NUM_PE = pe_stream_pkg::NUM_PORTS - 1;
    localparam int PEW    = $clog2(NUM_PE);
    localparam int TAGW   = IDW + USERW + 1;
    // TAG_DEPTH is a power of two no smaller than 2
    localparam int AW     = $clog2(TAG_DEPTH);

    // one tag FIFO per PE
    // the extra pointer bit tells full from empty
    logic [TAGW-1:0]   tag_mem [NUM_PE][TAG_DEPTH];
    logic [AW:0]       wr_ptr [NUM_PE];
    logic [AW:0]       rd_ptr [NUM_PE];
    logic [NUM_PE-1:0] fifo_full;

    logic [PEW-1:0]    s_pe;
    logic [PEW-1:0]    r_pe;
    logic              s_accept;
    logic              r_accept;
    logic [TAGW-1:0]   head_tag;

    assign s_pe = axis_s_tdest[PEW-1:0];
    // port 0 is the dispatcher itself, so PE k sits on port k+1
    assign r_pe = PEW'(rsp_tsrc - PW'(1));

    always_comb begin
        for (int k = 0; k < NUM_PE; k++) begin
            fifo_full[k] = (wr_ptr[k][AW] != rd_ptr[k][AW]) &&
                           (wr_ptr[k][AW-1:0] == rd_ptr[k][AW-1:0]);
        end
    end

    // refuse while the request register is stuck or the tag FIFO is full
    assign axis_s_tready = !(req_tvalid && !req_tready) && !fifo_full[s_pe];
    assign s_accept      = axis_s_tvalid && axis_s_tready;

    assign rsp_tready = !axis_m_tvalid || axis_m_tready;
    assign r_accept   = rsp_tvalid && rsp_tready;
    assign head_tag   = tag_mem[r_pe][rd_ptr[r_pe][AW-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NUM_PE; k++) begin
                wr_ptr[k] <= '0;
                rd_ptr[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_PE; k++) begin
                if (s_accept && (s_pe == PEW'(k))) begin
                    wr_ptr[k] <= wr_ptr[k] + 1'b1;
                end
                if (r_accept && (r_pe == PEW'(k))) begin
                    rd_ptr[k] <= rd_ptr[k] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_accept) begin
            tag_mem[s_pe][wr_ptr[s_pe][AW-1:0]] <= {axis_s_tid, axis_s_tuser, axis_s_tlast};
        end
    end

    // request register toward switch port 0
    always_ff @(posedge clk) begin
        if (rst) begin
            req_tvalid <= 1'b0;
        end else if (s_accept) begin
            req_tvalid <= 1'b1;
        end else if (req_tready) begin
            req_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_accept) begin
            req_tdata <= axis_s_tdata;
            req_tdest <= PW'(s_pe) + PW'(1);
        end
    end

    // result register takes its tags from the head of the PE's FIFO
    always_ff @(posedge clk) begin
        if (rst) begin
            axis_m_tvalid <= 1'b0;
        end else if (r_accept) begin
            axis_m_tvalid <= 1'b1;
        end else if (axis_m_tready) begin
            axis_m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_accept) begin
            axis_m_tdata                             <= rsp_tdata;
            {axis_m_tid, axis_m_tuser, axis_m_tlast} <= head_tag;
            axis_m_tdest                             <= DESTW'(r_pe);
        end
    end

endmodule

// ==== source/pe_stream_switch.sv ====
`timescale 1ns/10ps

module pe_stream_switch #(
    parameter int DATAW     = 128,
    parameter int IDW       = 2,
    parameter int USERW     = 4,
    parameter int DESTW     = 4,
    parameter int TAG_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,

    // external request stream
    input  logic             axis_s_tvalid,
    output logic             axis_s_tready,
    input  logic [DATAW-1:0] axis_s_tdata,
    input  logic             axis_s_tlast,
    input  logic [IDW-1:0]   axis_s_tid,
    input  logic [USERW-1:0] axis_s_tuser,
    input  logic [DESTW-1:0] axis_s_tdest,

    // external result stream
    output logic             axis_m_tvalid,
    input  logic             axis_m_tready,
    output logic [DATAW-1:0] axis_m_tdata,
    output logic             axis_m_tlast,
    output logic [IDW-1:0]   axis_m_tid,
    output logic [USERW-1:0] axis_m_tuser,
    output logic [DESTW-1:0] axis_m_tdest
);

    localparam int N  = pe_stream_pkg::NUM_PORTS;
    localparam int PW = pe_stream_pkg::PORTW;

    logic [N-1:0]       sw_s_tvalid;
    logic [N-1:0]       sw_s_tready;
    logic [N*DATAW-1:0] sw_s_tdata;
    logic [N*PW-1:0]    sw_s_tdest;
    logic [N-1:0]       sw_m_tvalid;
    logic [N-1:0]       sw_m_tready;
    logic [N*DATAW-1:0] sw_m_tdata;
    logic [N*PW-1:0]    sw_m_tsrc;

    // every PE result heads back to port 0
    assign sw_s_tdest[N*PW-1:PW] = '0;

    task_dispatcher #(
        .DATAW(DATAW), .IDW(IDW), .USERW(USERW), .DESTW(DESTW), .TAG_DEPTH(TAG_DEPTH)
    ) i_dispatcher (
        .clk           (clk),
        .rst           (rst),
        .axis_s_tvalid (axis_s_tvalid),
        .axis_s_tready (axis_s_tready),
        .axis_s_tdata  (axis_s_tdata),
        .axis_s_tlast  (axis_s_tlast),
        .axis_s_tid    (axis_s_tid),
        .axis_s_tuser  (axis_s_tuser),
        .axis_s_tdest  (axis_s_tdest),
        .axis_m_tvalid (axis_m_tvalid),
        .axis_m_tready (axis_m_tready),
        .axis_m_tdata  (axis_m_tdata),
        .axis_m_tlast  (axis_m_tlast),
        .axis_m_tid    (axis_m_tid),
        .axis_m_tuser  (axis_m_tuser),
        .axis_m_tdest  (axis_m_tdest),
        .req_tvalid    (sw_s_tvalid[0]),
        .req_tready    (sw_s_tready[0]),
        .req_tdata     (sw_s_tdata[0 +: DATAW]),
        .req_tdest     (sw_s_tdest[0 +: PW]),
        .rsp_tvalid    (sw_m_tvalid[0]),
        .rsp_tready    (sw_m_tready[0]),
        .rsp_tdata     (sw_m_tdata[0 +: DATAW]),
        .rsp_tsrc      (sw_m_tsrc[0 +: PW])
    );

    axis_pe #(.DATAW(DATAW), .OP(pe_stream_pkg::OP_INC)) i_pe0 (
        .clk(clk), .rst(rst),
        .in_tvalid(sw_m_tvalid[1]), .in_tready(sw_m_tready[1]),
        .in_tdata(sw_m_tdata[1*DATAW +: DATAW]),
        .out_tvalid(sw_s_tvalid[1]), .out_tready(sw_s_tready[1]),
        .out_tdata(sw_s_tdata[1*DATAW +: DATAW])
    );

    axis_pe #(.DATAW(DATAW), .OP(pe_stream_pkg::OP_XOR)) i_pe1 (
        .clk(clk), .rst(rst),
        .in_tvalid(sw_m_tvalid[2]), .in_tready(sw_m_tready[2]),
        .in_tdata(sw_m_tdata[2*DATAW +: DATAW]),
        .out_tvalid(sw_s_tvalid[2]), .out_tready(sw_s_tready[2]),
        .out_tdata(sw_s_tdata[2*DATAW +: DATAW])
    );

    axis_pe #(.DATAW(DATAW), .OP(pe_stream_pkg::OP_ROTL)) i_pe2 (
        .clk(clk), .rst(rst),
        .in_tvalid(sw_m_tvalid[3]), .in_tready(sw_m_tready[3]),
        .in_tdata(sw_m_tdata[3*DATAW +: DATAW]),
        .out_tvalid(sw_s_tvalid[3]), .out_tready(sw_s_tready[3]),
        .out_tdata(sw_s_tdata[3*DATAW +: DATAW])
    );

    axis_pe #(.DATAW(DATAW), .OP(pe_stream_pkg::OP_SWAP)) i_pe3 (
        .clk(clk), .rst(rst),
        .in_tvalid(sw_m_tvalid[4]), .in_tready(sw_m_tready[4]),
        .in_tdata(sw_m_tdata[4*DATAW +: DATAW]),
        .out_tvalid(sw_s_tvalid[4]), .out_tready(sw_s_tready[4]),
        .out_tdata(sw_s_tdata[4*DATAW +: DATAW])
    );

    stream_switch #(.DATAW(DATAW)) i_switch (
        .clk      (clk),
        .rst      (rst),
        .s_tvalid (sw_s_tvalid),
        .s_tready (sw_s_tready),
        .s_tdata  (sw_s_tdata),
        .s_tdest  (sw_s_tdest),
        .m_tvalid (sw_m_tvalid),
        .m_tready (sw_m_tready),
        .m_tdata  (sw_m_tdata),
        .m_tsrc   (sw_m_tsrc)
    );

endmodule

// ==== tests/pe_ref_model.svh ====
`ifndef PE_REF_MODEL_SVH
`define PE_REF_MODEL_SVH

localparam int NUM_PE    = 4;
localparam int LW        = pe_stream_pkg::LANEW;
localparam int NUM_LANES = DATAW / LW;

typedef struct packed {
    logic [DATAW-1:0] data;
    logic [IDW-1:0]   id;
    logic [USERW-1:0] user;
    logic             last;
} exp_beat_t;

// expected results per PE with the oldest at the front
exp_beat_t exp_q [NUM_PE][$];

// each PE has its operation fixed by position
function automatic pe_stream_pkg::pe_op_e op_for_pe(input logic [1:0] pe);
    case (pe)
        2'd0:    return pe_stream_pkg::OP_INC;
        2'd1:    return pe_stream_pkg::OP_XOR;
        2'd2:    return pe_stream_pkg::OP_ROTL;
        default: return pe_stream_pkg::OP_SWAP;
    endcase
endfunction

function automatic logic [DATAW-1:0] expected_data(input pe_stream_pkg::pe_op_e op,
                                                   input logic [DATAW-1:0] d);
    logic [DATAW-1:0] r;
    logic [LW-1:0]    lane;
    r = d;
    for (int l = 0; l < NUM_LANES; l++) begin
        lane = d[l*LW +: LW];
        if (op == pe_stream_pkg::OP_INC) begin
            r[l*LW +: LW] = lane + LW'(1);
        end else if (op == pe_stream_pkg::OP_XOR) begin
            r[l*LW +: LW] = lane ^ pe_stream_pkg::XOR_KEY;
        end else if (op == pe_stream_pkg::OP_ROTL) begin
            r[l*LW +: LW] = {lane[LW-9:0], lane[LW-1:LW-8]};
        end else begin
            // lane l lands at the mirrored position
            r[(NUM_LANES-1-l)*LW +: LW] = lane;
        end
    end
    return r;
endfunction

function automatic int pending_total();
    int n;
    n = 0;
    for (int k = 0; k < NUM_PE; k++) begin
        n += exp_q[k].size();
    end
    return n;
endfunction

`endif

// ==== tests/pe_stream_switch_tb.sv ====
`timescale 1ns/10ps

module pe_stream_switch_tb;

    localparam int DATAW      = 128;
    localparam int IDW        = 2;
    localparam int USERW      = 4;
    localparam int DESTW      = 4;
    localparam int TAG_DEPTH  = 4;
    localparam int WAIT_LIMIT = 2000;

    logic             clk;
    logic             rst;
    logic             axis_s_tvalid;
    logic             axis_s_tready;
    logic [DATAW-1:0] axis_s_tdata;
    logic             axis_s_tlast;
    logic [IDW-1:0]   axis_s_tid;
    logic [USERW-1:0] axis_s_tuser;
    logic [DESTW-1:0] axis_s_tdest;
    logic             axis_m_tvalid;
    logic             axis_m_tready;
    logic [DATAW-1:0] axis_m_tdata;
    logic             axis_m_tlast;
    logic [IDW-1:0]   axis_m_tid;
    logic [USERW-1:0] axis_m_tuser;
    logic [DESTW-1:0] axis_m_tdest;

    // sink mode picks always ready (0), random (1) or stalled (2)
    int sink_mode;

    `include "pe_ref_model.svh"

    pe_stream_switch #(
        .DATAW(DATAW), .IDW(IDW), .USERW(USERW), .DESTW(DESTW), .TAG_DEPTH(TAG_DEPTH)
    ) i_pe_stream_switch (
        .clk           (clk),
        .rst           (rst),
        .axis_s_tvalid (axis_s_tvalid),
        .axis_s_tready (axis_s_tready),
        .axis_s_tdata  (axis_s_tdata),
        .axis_s_tlast  (axis_s_tlast),
        .axis_s_tid    (axis_s_tid),
        .axis_s_tuser  (axis_s_tuser),
        .axis_s_tdest  (axis_s_tdest),
        .axis_m_tvalid (axis_m_tvalid),
        .axis_m_tready (axis_m_tready),
        .axis_m_tdata  (axis_m_tdata),
        .axis_m_tlast  (axis_m_tlast),
        .axis_m_tid    (axis_m_tid),
        .axis_m_tuser  (axis_m_tuser),
        .axis_m_tdest  (axis_m_tdest)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [DATAW-1:0] got,
                                   input logic [DATAW-1:0] exp);
        report_failure($sformatf("FAILED %s: got %0h expected %0h", name, got, exp));
    endtask

    function automatic logic [DATAW-1:0] random_data();
        logic [DATAW-1:0] d;
        for (int w = 0; w < NUM_LANES; w++) begin
            d[w*LW +: LW] = $urandom();
        end
        return d;
    endfunction

    // enters and returns on a falling edge
    task automatic send_beat(input logic [DESTW-1:0] dest, input logic [DATAW-1:0] data,
                             input logic [IDW-1:0] id, input logic [USERW-1:0] user,
                             input logic last);
        exp_beat_t e;
        int        cycles;
        logic      done;
        e.data = expected_data(op_for_pe(dest[1:0]), data);
        e.id   = id;
        e.user = user;
        e.last = last;
        cycles = 0;
        done   = 1'b0;
        axis_s_tvalid = 1'b1;
        axis_s_tdata  = data;
        axis_s_tid    = id;
        axis_s_tuser  = user;
        axis_s_tlast  = last;
        axis_s_tdest  = dest;
        while (!done) begin
            #1;
            if (axis_s_tready) begin
                exp_q[dest[1:0]].push_back(e);
                done = 1'b1;
            end else if (cycles == WAIT_LIMIT) begin
                report_failure("request port did not accept a beat in time");
            end
            cycles++;
            @(negedge clk);
        end
        axis_s_tvalid = 1'b0;
    endtask

    task automatic send_random(input int count);
        for (int n = 0; n < count; n++) begin
            send_beat(DESTW'($urandom()), random_data(), IDW'($urandom()),
                      USERW'($urandom()), 1'($urandom()));
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending_total() != 0) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure("results still outstanding after the drain timeout");
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    // stall the output and flood PE 2 until the input pushes back
    task automatic stall_one_pe();
        int stuck;
        int cycles;
        stuck     = 0;
        cycles    = 0;
        sink_mode = 2;
        fork
            for (int n = 0; n < 16; n++) begin
                send_beat((DESTW'($urandom()) & ~DESTW'(3)) | DESTW'(2), random_data(),
                          IDW'($urandom()), USERW'($urandom()), 1'($urandom()));
            end
            begin
                while (stuck < 20) begin
                    @(negedge clk);
                    #1;
                    if (axis_s_tvalid && !axis_s_tready) begin
                        stuck++;
                    end else begin
                        stuck = 0;
                    end
                    if (cycles == WAIT_LIMIT) begin
                        report_failure("request port never pushed back under a stalled output");
                    end
                    cycles++;
                end
                // pushback comes from a full tag FIFO for PE 2
                assert (exp_q[2].size() >= TAG_DEPTH)
                    else report_failure("input pushed back before the tag FIFO filled");
                sink_mode = 0;
            end
        join
    endtask

    // sink and scoreboard
    initial begin : sink
        exp_beat_t        e;
        exp_beat_t        held_beat;
        logic [DESTW-1:0] held_dest;
        logic             held;
        logic [1:0]       pe;
        axis_m_tready = 1'b0;
        held = 1'b0;
        forever begin
            @(negedge clk);
            if (sink_mode == 0) begin
                axis_m_tready = 1'b1;
            end else if (sink_mode == 1) begin
                axis_m_tready = ($urandom() % 2) == 0;
            end else begin
                axis_m_tready = 1'b0;
            end
            #1;
            // a stalled beat must not change
            if (held) begin
                assert (axis_m_tvalid) else report_failure("result valid dropped before transfer");
                assert (axis_m_tdata == held_beat.data)
                    else report_mismatch("axis_m_tdata", axis_m_tdata, held_beat.data);
                assert ({axis_m_tid, axis_m_tuser, axis_m_tlast} ==
                        {held_beat.id, held_beat.user, held_beat.last})
                    else report_mismatch("axis_m_tid/tuser/tlast",
                                         {axis_m_tid, axis_m_tuser, axis_m_tlast},
                                         {held_beat.id, held_beat.user, held_beat.last});
                assert (axis_m_tdest == held_dest)
                    else report_mismatch("axis_m_tdest", axis_m_tdest, held_dest);
            end
            if (axis_m_tvalid && axis_m_tready) begin
                assert (axis_m_tdest < DESTW'(NUM_PE))
                    else report_mismatch("axis_m_tdest", axis_m_tdest, 3);
                pe = axis_m_tdest[1:0];
                assert (exp_q[pe].size() > 0)
                    else report_failure("result arrived from a PE with no beat outstanding");
                e = exp_q[pe].pop_front();
                assert (axis_m_tdata == e.data)
                    else report_mismatch("axis_m_tdata", axis_m_tdata, e.data);
                assert (axis_m_tid == e.id) else report_mismatch("axis_m_tid", axis_m_tid, e.id);
                assert (axis_m_tuser == e.user)
                    else report_mismatch("axis_m_tuser", axis_m_tuser, e.user);
                assert (axis_m_tlast == e.last)
                    else report_mismatch("axis_m_tlast", axis_m_tlast, e.last);
                held = 1'b0;
            end else if (axis_m_tvalid) begin
                held           = 1'b1;
                held_beat.data = axis_m_tdata;
                held_beat.id   = axis_m_tid;
                held_beat.user = axis_m_tuser;
                held_beat.last = axis_m_tlast;
                held_dest      = axis_m_tdest;
            end else begin
                held = 1'b0;
            end
        end
    end

    initial begin : main
        int cycles;
        void'($urandom(32'hd89b_f679));
        clk           = 1'b0;
        rst           = 1'b1;
        sink_mode     = 0;
        axis_s_tvalid = 1'b0;
        axis_s_tdata  = '0;
        axis_s_tlast  = 1'b0;
        axis_s_tid    = '0;
        axis_s_tuser  = '0;
        axis_s_tdest  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            #1;
            assert (!axis_m_tvalid) else report_mismatch("axis_m_tvalid", axis_m_tvalid, 0);
        end
        cycles = 0;
        while (!axis_s_tready) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure("request port never became ready after reset");
            end
            cycles++;
            @(negedge clk);
            #1;
        end
        @(negedge clk);

        // one beat per PE
        for (int k = 0; k < NUM_PE; k++) begin
            send_beat(DESTW'(k), {32'h0123_4567, 32'h89ab_cdef, 32'hffff_ffff, 32'(k)},
                      IDW'(k), USERW'(4'ha - k), 1'(k % 2));
            wait_drain();
        end

        sink_mode = 0;
        send_random(200);
        wait_drain();

        sink_mode = 1;
        send_random(200);
        wait_drain();

        stall_one_pe();
        wait_drain();

        // nothing may come out once every result has arrived
        for (int n = 0; n < 32; n++) begin
            @(negedge clk);
            #1;
            assert (!axis_m_tvalid) else report_mismatch("axis_m_tvalid", axis_m_tvalid, 0);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+tests
source/pe_stream_pkg.sv
source/rr_arbiter.sv
source/stream_switch.sv
source/axis_pe.sv
source/task_dispatcher.sv
source/pe_stream_switch.sv
tests/pe_stream_switch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, result decided from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module pe_stream_switch_tb -o pe_stream_switch_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/pe_stream_switch_sim > sim.log 2>&1
cat sim.log

grep -q "^TESTS PASSED$" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
